//--- tb.f
verilog/usbRxPkg.sv
verilog/usbRxByteIf.sv
verilog/usbLineSync.sv
verilog/usbDpll.sv
verilog/usbRxDecoder.sv
verilog/usbRxPacketCheck.sv
verilog/usbRxFifo.sv
verilog/usbRxTop.sv
dv/usbHostModel.sv
dv/usbRxTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= usbRxTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/usbRxTb.sv
module usbRxTb import usbRxPkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PACKETS = 31; // every packet, SE0 period and outEn burst below
    localparam int MAX_PKT_CYCLES = 600; // a 12-byte packet with stuffing and idle gap
    localparam int CYCLE_LIMIT = NUM_PACKETS * MAX_PKT_CYCLES * 2 + 2000;

    logic clk48 = 1'b0;
    logic arstN;
    logic usbDp;
    logic usbDn;
    logic outEn;
    logic ackUsbRst;
    logic usbResetDetect;
    logic rxAcceptNewData;
    logic rxDataValid;
    logic rxIsLastByte;
    logic [7:0] rxData;
    logic keepPacket;
    logic holdAccept; // backend stalls completely
    logic txWindow; // receiver blanked, nothing may come out
    logic resetAllowed; // bus reset is being driven on purpose
    int mismatches = 0;
    int failures = 0;
    int cycles = 0;

    always #10 clk48 = !clk48;

    usbRxTop i_dut (.*);

    usbHostModel host (.clk48(clk48), .usbDp(usbDp), .usbDn(usbDn));

    always @(negedge clk48) begin
        rxAcceptNewData <= !holdAccept && ($urandom % 4 != 0); // accept about three in four
    end

    always @(posedge clk48) begin : scoreboard
        rxEntry exp;
        cycles++;
        if (arstN && rxDataValid && rxAcceptNewData) begin
            if (host.expQ.size() == 0) begin
                failures++;
                $display("Unexpected byte %h delivered at %0t", rxData, $time);
            end else begin
                exp = host.expQ.pop_front();
                assert (rxData == exp.data) else begin
                    mismatches++;
                    $display("Mismatch at %0t: rxData got %h expected %h", $time, rxData, exp.data);
                end
                assert (rxIsLastByte == exp.last) else begin
                    mismatches++;
                    $display("Mismatch at %0t: rxIsLastByte got %b expected %b",
                        $time, rxIsLastByte, exp.last);
                end
                assert (!exp.last || keepPacket == exp.keep) else begin
                    mismatches++;
                    $display("Mismatch at %0t: keepPacket got %b expected %b",
                        $time, keepPacket, exp.keep);
                end
            end
        end
        assert (!arstN || !txWindow || !rxDataValid) else begin
            failures++;
            $display("Byte came out while outEn was high at %0t", $time);
        end
        assert (!arstN || resetAllowed || !usbResetDetect) else begin
            failures++;
            $display("Bus reset flagged without a long SE0 at %0t", $time);
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("Something failed");
            $finish;
        end
    end

    task automatic drain();
        int waited;
        waited = 0;
        while ((host.expQ.size() != 0 || rxDataValid) && waited < 2 * MAX_PKT_CYCLES) begin
            @(posedge clk48);
            waited++;
        end
        if (host.expQ.size() != 0) begin
            failures++;
            $display("%0d expected bytes never arrived", host.expQ.size());
            host.expQ.delete(); // later packets are compared from a clean queue
        end
        repeat (4) @(posedge clk48);
    endtask

    task automatic randomPacket(input int corrupt);
        logic [7:0] payload [$];
        logic [3:0] tokPid [3] = '{4'h1, 4'h9, 4'hD}; // OUT, IN, SETUP
        logic [3:0] datPid [2] = '{4'h3, 4'hB}; // DATA0, DATA1
        logic [3:0] hsPid [3] = '{4'h2, 4'hA, 4'hE}; // ACK, NAK, STALL
        int kind;
        int len;
        kind = (corrupt == 1) ? $urandom % 2 : $urandom % 3; // handshakes carry no CRC
        len = (kind == 0) ? 2 : (kind == 1) ? $urandom % 8 : 0;
        repeat (len) payload.push_back(8'($urandom));
        case (kind)
            0: host.sendPacket(0, tokPid[$urandom % 3], payload, corrupt, 1'b0, 1'b0, 1'b1);
            1: host.sendPacket(1, datPid[$urandom % 2], payload, corrupt, 1'b0, 1'b0, 1'b1);
            default: host.sendPacket(2, hsPid[$urandom % 3], payload, corrupt, 1'b0, 1'b0, 1'b1);
        endcase
    endtask

    task automatic ffPacket(input int len, input logic violate);
        logic [7:0] payload [$];
        repeat (len) payload.push_back(8'hFF); // long runs of ones force stuffing
        host.sendPacket(1, 4'h3, payload, 0, violate, 1'b0, 1'b1);
    endtask

    initial begin
        logic [7:0] payload [$];
        arstN = 1'b0;
        outEn = 1'b0;
        ackUsbRst = 1'b0;
        rxAcceptNewData = 1'b0;
        holdAccept = 1'b0;
        txWindow = 1'b0;
        resetAllowed = 1'b0;
        void'($urandom(84));
        repeat (8) @(posedge clk48);
        @(negedge clk48) arstN = 1'b1;
        repeat (10) @(posedge clk48);
        repeat (20) randomPacket(0);
        repeat (2) randomPacket(1);
        repeat (2) randomPacket(2);
        ffPacket(4, 1'b0);
        ffPacket(7, 1'b0);
        ffPacket(3, 1'b1);
        drain();
        holdAccept = 1'b1; // twelve bytes into an eight-entry FIFO
        repeat (9) payload.push_back(8'($urandom));
        host.sendPacket(1, 4'hB, payload, 0, 1'b0, 1'b1, 1'b1);
        repeat (40) @(posedge clk48);
        holdAccept = 1'b0;
        drain();
        resetAllowed = 1'b1;
        host.driveSe0(150);
        repeat (20) @(posedge clk48);
        assert (usbResetDetect) else begin
            failures++;
            $display("usbResetDetect did not stay high after a 150 cycle SE0");
        end
        @(negedge clk48) ackUsbRst = 1'b1;
        @(negedge clk48) ackUsbRst = 1'b0;
        repeat (2) @(posedge clk48);
        assert (!usbResetDetect) else begin
            failures++;
            $display("usbResetDetect did not clear after ackUsbRst");
        end
        resetAllowed = 1'b0;
        drain();
        @(negedge clk48);
        outEn = 1'b1;
        txWindow = 1'b1;
        repeat (2) randomPacket(0);
        host.expQ.delete(); // the blanked receiver must not deliver these
        repeat (20) @(posedge clk48);
        @(negedge clk48);
        txWindow = 1'b0;
        outEn = 1'b0;
        repeat (20) @(posedge clk48);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dv/usbHostModel.sv
module usbHostModel import usbRxPkg::*; (
    input  logic clk48,
    output logic usbDp,
    output logic usbDn
);

    timeunit 1ns;
    timeprecision 100ps;

    rxEntry expQ [$]; // bytes the receiver must hand to the backend, oldest first
    logic level = 1'b1; // current NRZI line level, 1 is J

    initial begin
        usbDp = 1'b1; // bus idles at J
        usbDn = 1'b0;
    end

    // serial CRC5 over a bit list, x^5 + x^2 + 1 with an all-ones start
    function automatic logic [4:0] crc5Bits(input logic b [$]);
        logic [4:0] r;
        logic fb;
        r = 5'h1F;
        foreach (b[i]) begin
            fb = r[4] ^ b[i];
            r = {r[3:0], 1'b0};
            if (fb) r = r ^ 5'b00101;
        end
        return r;
    endfunction

    // serial CRC16 over a bit list, x^16 + x^15 + x^2 + 1
    function automatic logic [15:0] crc16Bits(input logic b [$]);
        logic [15:0] r;
        logic fb;
        r = 16'hFFFF;
        foreach (b[i]) begin
            fb = r[15] ^ b[i];
            r = {r[14:0], 1'b0};
            if (fb) r = r ^ 16'h8005;
        end
        return r;
    endfunction

    task automatic lineBit(input logic dp, input logic dn);
        @(negedge clk48);
        usbDp = dp;
        usbDn = dn;
        repeat (SAMPLES_PER_BIT - 1) @(negedge clk48); // hold for one full bit cell
    endtask

    task automatic nrziBit(input logic b);
        if (!b) level = !level; // a zero is sent as a transition
        lineBit(level, !level);
    endtask

    task automatic driveSe0(input int cycles);
        @(negedge clk48);
        usbDp = 1'b0;
        usbDn = 1'b0;
        repeat (cycles - 1) @(negedge clk48);
        usbDp = 1'b1; // back to idle J
        usbDn = 1'b0;
        repeat (8) @(negedge clk48);
    endtask

    // kind 0 token, 1 data, 2 handshake; corrupt 1 flips a CRC bit, 2 breaks the PID
    task automatic sendPacket(input int kind, input logic [3:0] pid, input logic [7:0] payload [$],
            input int corrupt, input logic violate, input logic overflow, input logic record);
        logic field [$];
        logic bits [$];
        logic kept [$];
        logic wireBits [$];
        logic [4:0] c5;
        logic [15:0] c16;
        logic [7:0] pidByte;
        logic [7:0] b;
        int ones;
        int eat;
        int nBytes;
        int nField;
        pidByte = {~pid, pid};
        if (corrupt == 2) pidByte[6] = !pidByte[6]; // complement no longer matches
        nField = (kind == 0) ? 11 : (kind == 1) ? 8 * payload.size() : 0;
        for (int i = 0; i < nField; i++) field.push_back(payload[i / 8][i % 8]);
        if (kind == 0) begin
            c5 = crc5Bits(field);
            for (int i = 4; i >= 0; i--) field.push_back(!c5[i]); // inverted, MSB first
        end else if (kind == 1) begin
            c16 = crc16Bits(field);
            for (int i = 15; i >= 0; i--) field.push_back(!c16[i]);
        end
        if (corrupt == 1) field[field.size() - 3] = !field[field.size() - 3];
        for (int i = 0; i < 8; i++) bits.push_back(pidByte[i]);
        foreach (field[i]) bits.push_back(field[i]);
        ones = 1; // the trailing one of SYNC starts the run
        eat = -1;
        foreach (bits[i]) begin
            if (ones == 6) begin
                if (violate && eat < 0) begin
                    eat = i; // a data one takes the stuff slot and is thrown away
                end else begin
                    wireBits.push_back(1'b0);
                end
                ones = 0;
            end
            wireBits.push_back(bits[i]);
            if (i != eat) begin
                ones = bits[i] ? ones + 1 : 0;
                kept.push_back(bits[i]);
            end
        end
        if (ones == 6) wireBits.push_back(1'b0); // stuff bit right before EOP
        nBytes = kept.size() / 8; // a partial byte never reaches the backend
        for (int k = 0; k < nBytes && record; k++) begin
            for (int j = 0; j < 8; j++) b[j] = kept[8 * k + j];
            // with the FIFO full only the first seven and the final byte survive
            if (!overflow || k < RX_FIFO_DEPTH - 1 || k == nBytes - 1) begin
                expQ.push_back(rxEntry'{data: b, last: k == nBytes - 1,
                    keep: k == nBytes - 1 && corrupt == 0 && !violate && !overflow});
            end
        end
        level = 1'b1;
        repeat (7) nrziBit(1'b0); // SYNC is seven zeros then a one
        nrziBit(1'b1);
        foreach (wireBits[i]) nrziBit(wireBits[i]);
        lineBit(1'b0, 1'b0); // EOP is two bits of SE0 and one of J
        lineBit(1'b0, 1'b0);
        level = 1'b1;
        repeat (5) lineBit(1'b1, 1'b0);
    endtask

endmodule

//--- verilog/usbRxTop.sv
module usbRxTop import usbRxPkg::*; (
    input  logic clk48,
    input  logic arstN,
    input  logic usbDp,
    input  logic usbDn,
    input  logic outEn,
    input  logic ackUsbRst,
    output logic usbResetDetect,
    input  logic rxAcceptNewData, // backend takes the head byte this cycle
    output logic rxDataValid, // rxData holds a byte not yet taken
    output logic rxIsLastByte, // head byte closes its packet
    output logic [7:0] rxData,
    output logic keepPacket // packet is good, read it together with rxIsLastByte
);

    logic lineP;
    logic lineN;
    logic bitStrobe;
    logic push;
    logic overflowSeen;
    rxEntry entry;

    usbRxByteIf byteIf ();

    usbLineSync lineSync (
        .clk48(clk48),
        .arstN(arstN),
        .usbDp(usbDp),
        .usbDn(usbDn),
        .ackUsbRst(ackUsbRst),
        .lineP(lineP),
        .lineN(lineN),
        .usbResetDetect(usbResetDetect)
    );

    usbDpll dpll (
        .clk48(clk48),
        .arstN(arstN),
        .lineP(lineP),
        .outEn(outEn),
        .bitStrobe(bitStrobe)
    );

    usbRxDecoder decoder (
        .clk48(clk48),
        .arstN(arstN),
        .lineP(lineP),
        .lineN(lineN),
        .bitStrobe(bitStrobe),
        .outEn(outEn),
        .byteIf(byteIf.decoder)
    );

    usbRxPacketCheck packetCheck (
        .clk48(clk48),
        .arstN(arstN),
        .byteIf(byteIf.pktChecker),
        .push(push),
        .entry(entry),
        .overflowSeen(overflowSeen)
    );

    usbRxFifo fifo (
        .clk48(clk48),
        .arstN(arstN),
        .push(push),
        .entry(entry),
        .rxAcceptNewData(rxAcceptNewData),
        .overflowSeen(overflowSeen),
        .rxDataValid(rxDataValid),
        .rxIsLastByte(rxIsLastByte),
        .rxData(rxData),
        .keepPacket(keepPacket)
    );

endmodule

//--- verilog/usbRxFifo.sv
module usbRxFifo import usbRxPkg::*; (
    input  logic clk48,
    input  logic arstN,
    input  logic push,
    input  rxEntry entry,
    input  logic rxAcceptNewData,
    output logic overflowSeen,
    output logic rxDataValid,
    output logic rxIsLastByte,
    output logic [7:0] rxData,
    output logic keepPacket
);

    typedef logic [$clog2(RX_FIFO_DEPTH) - 1:0] ptrT;
    typedef logic [$clog2(RX_FIFO_DEPTH + 1) - 1:0] cntT;

    function automatic ptrT ptrInc(input ptrT p);
        return (p == ptrT'(RX_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    rxEntry mem [RX_FIFO_DEPTH];
    rxEntry head;
    ptrT rdPtr;
    ptrT wrPtr;
    ptrT newestPtr; // slot written most recently
    ptrT wrIdx;
    cntT count;
    logic pop;
    logic full; // no room for this push even counting a same-cycle pop
    logic wrNew; // normal append
    logic wrOver; // final byte replaces the newest entry
    logic drop; // payload byte lost, packet goes bad

    assign pop = rxDataValid && rxAcceptNewData;
    assign full = count == cntT'(RX_FIFO_DEPTH) && !pop;
    assign wrNew = push && !full;
    assign wrOver = push && full && entry.last;
    assign drop = push && full && !entry.last;
    assign newestPtr = (wrPtr == '0) ? ptrT'(RX_FIFO_DEPTH - 1) : wrPtr - 1'b1;
    assign wrIdx = wrOver ? newestPtr : wrPtr;

    always_ff @(posedge clk48) begin
        if (wrNew || wrOver) begin
            // overwritten tail still closes the packet, but as a rejected one
            mem[wrIdx] <= wrOver ? rxEntry'{data: entry.data, last: 1'b1, keep: 1'b0} : entry;
        end
    end

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            overflowSeen <= 1'b0;
        end else begin
            if (wrNew) begin
                wrPtr <= ptrInc(wrPtr);
            end
            if (pop) begin
                rdPtr <= ptrInc(rdPtr);
            end
            if (wrNew && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wrNew) begin
                count <= count - 1'b1;
            end
            if (drop) begin
                overflowSeen <= 1'b1;
            end else if (push && entry.last) begin
                overflowSeen <= 1'b0; // packet closed, next one starts clean
            end
        end
    end

    assign head = mem[rdPtr];
    assign rxDataValid = count != '0;
    assign rxData = head.data;
    assign rxIsLastByte = rxDataValid && head.last;
    assign keepPacket = rxIsLastByte && head.keep;

    occupancyBound: assert property (@(posedge clk48) disable iff (!arstN)
        count <= cntT'(RX_FIFO_DEPTH))
        else $error("FIFO occupancy %0d above depth", count);

endmodule

//--- verilog/usbRxPacketCheck.sv
module usbRxPacketCheck import usbRxPkg::*; (
    input  logic clk48,
    input  logic arstN,
    usbRxByteIf.pktChecker byteIf,
    output logic push,
    output rxEntry entry,
    input  logic overflowSeen
);

    function automatic logic [4:0] crc5Byte(input logic [4:0] crcIn, input logic [7:0] data);
        logic [4:0] c;
        c = crcIn;
        for (int i = 0; i < 8; i++) begin
            c = {c[3:0], 1'b0} ^ ((c[4] ^ data[i]) ? 5'h05 : 5'h00); // x^5 + x^2 + 1
        end
        return c;
    endfunction

    function automatic logic [15:0] crc16Byte(input logic [15:0] crcIn, input logic [7:0] data);
        logic [15:0] c;
        c = crcIn;
        for (int i = 0; i < 8; i++) begin
            c = {c[14:0], 1'b0} ^ ((c[15] ^ data[i]) ? 16'h8005 : 16'h0000); // x^16 + x^15 + x^2 + 1
        end
        return c;
    endfunction

    logic firstByte; // next byte on the interface is a PID
    logic pidOk; // PID of the current packet passed its complement check
    usbPidType pidType;
    logic [4:0] crc5;
    logic [15:0] crc16;
    logic [4:0] crc5Next;
    logic [15:0] crc16Next;
    logic pidGoodNow; // complement check of the byte on the interface
    usbPidType pidTypeNow;
    logic residueOk;
    logic keepNow; // keep decision if the byte on the interface is the last

    assign crc5Next = crc5Byte(crc5, byteIf.byteData);
    assign crc16Next = crc16Byte(crc16, byteIf.byteData);
    assign pidGoodNow = byteIf.byteData[3:0] == ~byteIf.byteData[7:4];
    assign pidTypeNow = usbPidType'({6'd0, byteIf.byteData[1:0]});

    always_comb begin
        case (pidType)
            pidData: residueOk = crc16Next == CRC16_RESIDUE;
            pidHandshake: residueOk = 1'b0; // a handshake must be the PID alone
            default: residueOk = crc5Next == CRC5_RESIDUE; // tokens and special PIDs carry CRC5
        endcase
        if (firstByte) begin
            keepNow = pidGoodNow && pidTypeNow == pidHandshake;
        end else begin
            keepNow = pidOk && residueOk;
        end
        keepNow = keepNow && !byteIf.lineError && !overflowSeen;
    end

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            push <= 1'b0;
            firstByte <= 1'b1;
        end else begin
            push <= byteIf.byteValid; // one cycle behind the decoder
            if (byteIf.byteValid) begin
                firstByte <= byteIf.isLast;
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (byteIf.byteValid) begin
            entry.data <= byteIf.byteData;
            entry.last <= byteIf.isLast;
            entry.keep <= byteIf.isLast && keepNow;
            if (firstByte) begin
                pidOk <= pidGoodNow;
                pidType <= pidTypeNow;
                crc5 <= 5'h1F; // both CRCs start all ones after the PID
                crc16 <= 16'hFFFF;
            end else begin
                crc5 <= crc5Next;
                crc16 <= crc16Next;
            end
        end
    end

endmodule

//--- verilog/usbRxDecoder.sv
module usbRxDecoder import usbRxPkg::*; (
    input logic clk48,
    input logic arstN,
    input logic lineP,
    input logic lineN,
    input logic bitStrobe,
    input logic outEn,
    usbRxByteIf.decoder byteIf
);

    usbRxState state;
    logic prevLevel; // lineP at the previous strobe, reference for NRZI
    logic [2:0] runCnt; // zeros during SYNC, consecutive ones during data
    logic [2:0] bitCnt; // bits of the current byte already shifted in
    logic [7:0] shiftReg; // LSB-first assembly register
    logic [7:0] holdByte; // completed byte held until we know if it is the last
    logic holdValid;
    logic stuffErr; // a one came where a stuff zero was due
    logic se0;
    logic rxBit; // NRZI-decoded bit at this strobe
    logic dataBit; // a real data bit, not a stuff bit, is taken
    logic byteDone; // that data bit completes a byte
    logic eopDone; // line back at J after SE0, packet over

    assign se0 = !lineP && !lineN;
    assign rxBit = lineP == prevLevel; // no transition decodes as 1
    assign dataBit = bitStrobe && !outEn && state == stData && !se0 && runCnt != 3'd6;
    assign byteDone = dataBit && bitCnt == 3'd7;
    assign eopDone = bitStrobe && !outEn && state == stEop && !se0;

    always_ff @(posedge clk48) begin
        if (dataBit) begin
            shiftReg <= {rxBit, shiftReg[7:1]};
        end
        if (byteDone) begin
            holdByte <= {rxBit, shiftReg[7:1]};
        end
        if (byteDone || eopDone) begin
            byteIf.byteData <= holdByte; // the previous byte goes out now
        end
    end

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            prevLevel <= 1'b1;
            runCnt <= '0;
            bitCnt <= '0;
            holdValid <= 1'b0;
            stuffErr <= 1'b0;
            byteIf.byteValid <= 1'b0;
            byteIf.isLast <= 1'b0;
            byteIf.lineError <= 1'b0;
        end else begin
            byteIf.byteValid <= 1'b0;
            if (outEn) begin
                state <= stIdle; // our own transmission is not received
                prevLevel <= 1'b1;
                holdValid <= 1'b0;
            end else if (bitStrobe) begin
                prevLevel <= lineP;
                case (state)
                    stIdle: begin
                        if (!lineP && lineN) begin
                            state <= stSync; // J to K is the first SYNC zero
                            runCnt <= 3'd1;
                        end
                    end
                    stSync: begin
                        if (se0) begin
                            state <= stIdle;
                        end else if (!rxBit) begin
                            runCnt <= (runCnt == 3'd7) ? runCnt : runCnt + 3'd1;
                        end else if (runCnt == 3'd7) begin
                            state <= stData;
                            runCnt <= 3'd1; // the trailing SYNC one counts toward stuffing
                            bitCnt <= '0;
                            stuffErr <= 1'b0;
                            holdValid <= 1'b0;
                        end else begin
                            state <= stIdle; // too few zeros, not a SYNC
                        end
                    end
                    stData: begin
                        if (se0) begin
                            state <= stEop;
                        end else if (runCnt == 3'd6) begin
                            runCnt <= '0; // stuff bit, dropped
                            stuffErr <= stuffErr || rxBit;
                        end else begin
                            bitCnt <= bitCnt + 3'd1;
                            runCnt <= rxBit ? runCnt + 3'd1 : 3'd0;
                        end
                    end
                    stEop: begin
                        if (!se0) begin
                            state <= stIdle;
                            holdValid <= 1'b0;
                        end
                    end
                    default: state <= stIdle;
                endcase
                if (byteDone) begin
                    holdValid <= 1'b1;
                    byteIf.byteValid <= holdValid; // the first byte only fills the hold stage
                    byteIf.isLast <= 1'b0;
                    byteIf.lineError <= 1'b0;
                end
                if (eopDone) begin
                    byteIf.byteValid <= holdValid;
                    byteIf.isLast <= 1'b1;
                    byteIf.lineError <= stuffErr || bitCnt != 3'd0; // leftover bits mean a partial byte
                end
            end
        end
    end

    stateLegal: assert property (@(posedge clk48) disable iff (!arstN)
        state inside {stIdle, stSync, stData, stEop})
        else $error("decoder state left its legal encodings");

    // bytes only come out of a packet body or its end, never from SYNC hunting
    validInPacket: assert property (@(posedge clk48) disable iff (!arstN)
        byteIf.byteValid |-> $past(state) inside {stData, stEop})
        else $error("byteValid outside of a packet");

endmodule

//--- verilog/usbDpll.sv
module usbDpll import usbRxPkg::*; (
    input  logic clk48,
    input  logic arstN,
    input  logic lineP,
    input  logic outEn,
    output logic bitStrobe
);

    logic lineQ; // lineP one cycle ago, for edge detection
    logic lineEdge; // lineP changed in the last cycle
    logic [1:0] phase; // cycles since the last lineP edge, modulo one bit time
    logic [1:0] phaseNext;

    assign lineEdge = lineP ^ lineQ;

    always_comb begin
        if (outEn) begin
            phaseNext = 2'd0; // transmitting, keep the tracker parked
        end else if (lineEdge) begin
            phaseNext = 2'd1; // the edge is already one cycle old here
        end else if (phase == 2'(SAMPLES_PER_BIT - 1)) begin
            phaseNext = 2'd0;
        end else begin
            phaseNext = phase + 2'd1;
        end
    end

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            lineQ <= 1'b1;
            phase <= 2'd0;
            bitStrobe <= 1'b0;
        end else begin
            lineQ <= lineP;
            phase <= phaseNext;
            bitStrobe <= phaseNext == 2'(STROBE_PHASE); // mid-bit sample point
        end
    end

    // the receiver is blind from the first cycle after outEn goes high
    noStrobeWhileTx: assert property (@(posedge clk48) disable iff (!arstN)
        outEn |=> !bitStrobe)
        else $error("bitStrobe fired while outEn was high");

endmodule

//--- verilog/usbLineSync.sv
module usbLineSync import usbRxPkg::*; (
    input  logic clk48,
    input  logic arstN,
    input  logic usbDp,
    input  logic usbDn,
    input  logic ackUsbRst,
    output logic lineP,
    output logic lineN,
    output logic usbResetDetect
);

    logic dpMeta; // first synchroniser stage for D+
    logic dnMeta; // first synchroniser stage for D-
    logic se0Q; // registered SE0 so the long counter starts from a clean flop
    logic [$clog2(USB_RESET_CYCLES + 1) - 1:0] se0Cnt; // consecutive SE0 cycles, saturating

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            dpMeta <= 1'b1; // come out of reset at idle J
            dnMeta <= 1'b0;
            lineP <= 1'b1;
            lineN <= 1'b0;
        end else begin
            dpMeta <= usbDp;
            dnMeta <= usbDn;
            lineP <= dpMeta; // two flops of latency from the pins
            lineN <= dnMeta;
        end
    end

    always_ff @(posedge clk48 or negedge arstN) begin
        if (!arstN) begin
            se0Q <= 1'b0;
            se0Cnt <= '0;
            usbResetDetect <= 1'b0;
        end else begin
            se0Q <= !lineP && !lineN;
            if (!se0Q) begin
                se0Cnt <= '0; // any J or K restarts the measurement
            end else if (se0Cnt != USB_RESET_CYCLES) begin
                se0Cnt <= se0Cnt + 1'b1;
            end
            if (ackUsbRst) begin
                usbResetDetect <= 1'b0;
            end else if (se0Q && se0Cnt == USB_RESET_CYCLES - 1) begin
                usbResetDetect <= 1'b1; // count passes this value once per SE0 period
            end
        end
    end

    // a rising flag needs SE0 on the line for the whole reset window before it
    resetNeedsSe0: assert property (@(posedge clk48) disable iff (!arstN)
        $rose(usbResetDetect) |-> $past(se0Q, USB_RESET_CYCLES))
        else $error("usbResetDetect rose without a full SE0 period");

endmodule

//--- verilog/usbRxByteIf.sv
interface usbRxByteIf;

    logic byteValid; // one-cycle strobe per decoded byte
    logic [7:0] byteData; // the byte, assembled LSB first
    logic isLast; // byte is the final one before EOP
    logic lineError; // stuff violation or partial byte, only valid with isLast

    modport decoder (
        output byteValid,
        output byteData,
        output isLast,
        output lineError
    );

    // read side, taken by the PID and CRC checker
    modport pktChecker (
        input byteValid,
        input byteData,
        input isLast,
        input lineError
    );

endinterface

//--- verilog/usbRxPkg.sv
package usbRxPkg;

    localparam int SAMPLES_PER_BIT = 4; // clk48 cycles per full-speed bit
    localparam int STROBE_PHASE = 2; // sample point in the middle of a bit cell
    localparam int USB_RESET_CYCLES = 120; // 2.5 us of SE0 at 48 MHz means bus reset
    localparam int RX_FIFO_DEPTH = 8; // bytes buffered toward the backend

    localparam logic [4:0] CRC5_RESIDUE = 5'b01100; // remainder left by a good token
    localparam logic [15:0] CRC16_RESIDUE = 16'h800D; // remainder left by a good data packet

    typedef enum logic [7:0] {
        stIdle, // line at J, waiting for the first K of SYNC
        stSync, // counting the NRZI zeros of SYNC
        stData, // unstuffing and shifting packet bits
        stEop // SE0 seen, waiting for the line to return to J
    } usbRxState;

    typedef enum logic [7:0] {
        pidSpecial = 8'd0, // PRE, ERR, SPLIT and PING
        pidToken = 8'd1, // OUT, IN, SOF and SETUP
        pidHandshake = 8'd2, // ACK, NAK, STALL and NYET
        pidData = 8'd3 // DATA0, DATA1, DATA2 and MDATA
    } usbPidType;

    typedef struct packed {
        logic [7:0] data; // received byte
        logic last; // final byte of its packet
        logic keep; // packet passed every check, only meaningful with last
    } rxEntry;

endpackage
